/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = icache_tb
FILELIST  = tb.f
BUILD_DIR = obj_dir
PASS_MSG  = *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* include/icache_defs.svh */
// Instruction cache geometry and configuration register map.
// Two ways, 64 sets, one 32-bit word per line.

`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

`define ICACHE_ADDR_W      32
`define ICACHE_WORD_W      32
`define ICACHE_SETS        64
`define ICACHE_IDX_W       6   // Address bits 7:2.
`define ICACHE_TAG_W       24  // Address bits 31:8.
`define ICACHE_AGE_W       3
`define ICACHE_AGE_MAX     7

`define ICACHE_CFG_AW      2
`define ICACHE_CFG_CTRL    2'd0
`define ICACHE_CFG_HITS    2'd1
`define ICACHE_CFG_MISSES  2'd2

`endif

/* sim/icache_props.sv */
// Handshake properties for the instruction cache top level.
// Response and refill requests must hold until taken, and flush
// writes may only arrive while the fetch port is idle.

`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_props (
    input logic                      clk,
    input logic                      rst,
    input logic                      i_req_ready,
    input logic                      i_rsp_valid,
    input logic                      i_rsp_ready,
    input icache_pkg::word_t         i_rsp_data,
    input logic                      i_mem_req_valid,
    input logic                      i_mem_req_ready,
    input icache_pkg::addr_t         i_mem_req_addr,
    input logic                      i_cfg_wr,
    input logic [`ICACHE_CFG_AW-1:0] i_cfg_addr,
    input icache_pkg::word_t         i_cfg_wdata
);

    int fail_count = 0;   // Read by the testbench at the end.

    a_rsp_hold: assert property (@(posedge clk) disable iff (!rst)
        i_rsp_valid && !i_rsp_ready |=> i_rsp_valid && $stable(i_rsp_data))
        else begin
            fail_count++;
            $error("response dropped or changed before it was accepted");
        end

    a_mem_req_hold: assert property (@(posedge clk) disable iff (!rst)
        i_mem_req_valid && !i_mem_req_ready |=> i_mem_req_valid && $stable(i_mem_req_addr))
        else begin
            fail_count++;
            $error("refill request dropped or changed before it was accepted");
        end

    a_flush_idle: assert property (@(posedge clk) disable iff (!rst)
        i_cfg_wr && (i_cfg_addr == `ICACHE_CFG_CTRL) && i_cfg_wdata[1] |-> i_req_ready)
        else begin
            fail_count++;
            $error("flush written while an access was in flight");
        end

endmodule

bind icache_top icache_props props_i (
    .clk             (clk),
    .rst             (rst),
    .i_req_ready     (o_req_ready),
    .i_rsp_valid     (o_rsp_valid),
    .i_rsp_ready     (i_rsp_ready),
    .i_rsp_data      (o_rsp_data),
    .i_mem_req_valid (o_mem_req_valid),
    .i_mem_req_ready (i_mem_req_ready),
    .i_mem_req_addr  (o_mem_req_addr),
    .i_cfg_wr        (i_cfg_wr),
    .i_cfg_addr      (i_cfg_addr),
    .i_cfg_wdata     (i_cfg_wdata)
);

/* sim/icache_tb.sv */
// Testbench for the two-way instruction cache.
// LFSR driven fetches and memory delays, a reference cache model,
// configuration register checks and a watchdog.

`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_tb;

    localparam logic [31:0] LFSR_SEED  = 32'h7e826934;
    localparam logic [31:0] MEM_XOR    = 32'ha5a5_0f0f;
    localparam int          N_RANDOM   = 40;
    localparam int          N_ACCESSES = 26 + N_RANDOM;

    logic                      clk;
    logic                      rst;
    logic                      i_req_valid;
    logic                      o_req_ready;
    icache_pkg::addr_t         i_req_addr;
    logic                      o_rsp_valid;
    logic                      i_rsp_ready;
    icache_pkg::word_t         o_rsp_data;
    logic                      o_mem_req_valid;
    logic                      i_mem_req_ready;
    icache_pkg::addr_t         o_mem_req_addr;
    logic                      i_mem_rsp_valid;
    icache_pkg::word_t         i_mem_rsp_data;
    logic                      i_cfg_wr;
    logic [`ICACHE_CFG_AW-1:0] i_cfg_addr;
    icache_pkg::word_t         i_cfg_wdata;
    icache_pkg::word_t         o_cfg_rdata;

    logic [31:0]       lfsr_q = LFSR_SEED;
    icache_pkg::addr_t refill_q [$];   // Refill addresses taken by the memory.

    logic              m_valid [2][`ICACHE_SETS];
    icache_pkg::tag_t  m_tag   [2][`ICACHE_SETS];
    icache_pkg::age_t  m_age   [2][`ICACHE_SETS];
    logic              m_enable;
    logic [31:0]       m_hits;
    logic [31:0]       m_misses;

    tb_clk_gen clk_gen_i (.o_clk(clk));

    icache_top dut_i (
        .clk             (clk),
        .rst             (rst),
        .i_req_valid     (i_req_valid),
        .o_req_ready     (o_req_ready),
        .i_req_addr      (i_req_addr),
        .o_rsp_valid     (o_rsp_valid),
        .i_rsp_ready     (i_rsp_ready),
        .o_rsp_data      (o_rsp_data),
        .o_mem_req_valid (o_mem_req_valid),
        .i_mem_req_ready (i_mem_req_ready),
        .o_mem_req_addr  (o_mem_req_addr),
        .i_mem_rsp_valid (i_mem_rsp_valid),
        .i_mem_rsp_data  (i_mem_rsp_data),
        .i_cfg_wr        (i_cfg_wr),
        .i_cfg_addr      (i_cfg_addr),
        .i_cfg_wdata     (i_cfg_wdata),
        .o_cfg_rdata     (o_cfg_rdata)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32, 22, 2, 1.
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    // Four tags over the low sets, so ways fill up and conflict.
    function automatic icache_pkg::addr_t pool_addr(input logic [1:0] t, input logic [5:0] s);
        return {22'h000400, t, s, 2'b00};
    endfunction

    task automatic stop_with_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    function automatic void model_touch(input icache_pkg::idx_t idx, input logic way);
        m_age[way][idx] = '0;
        if (m_age[~way][idx] != `ICACHE_AGE_MAX) begin
            m_age[~way][idx] = m_age[~way][idx] + 3'd1;
        end
    endfunction

    // Returns 1 when the access goes out to the refill port.
    function automatic logic model_access(input icache_pkg::addr_t addr);
        icache_pkg::idx_t idx;
        icache_pkg::tag_t tag;
        logic             way;
        idx = addr[`ICACHE_IDX_W+1:2];
        tag = addr[31:`ICACHE_IDX_W+2];
        if (!m_enable) begin
            return 1'b1;   // Bypass leaves the model alone.
        end
        for (int w = 0; w < 2; w++) begin
            if (m_valid[w][idx] && m_tag[w][idx] == tag) begin
                model_touch(idx, w[0]);
                m_hits = m_hits + 1;
                return 1'b0;
            end
        end
        if (!m_valid[0][idx]) begin
            way = 1'b0;
        end else if (!m_valid[1][idx]) begin
            way = 1'b1;
        end else begin
            way = (m_age[1][idx] > m_age[0][idx]);
        end
        m_valid[way][idx] = 1'b1;
        m_tag[way][idx] = tag;
        model_touch(idx, way);
        m_misses = m_misses + 1;
        return 1'b1;
    endfunction

    function automatic void model_clear(input logic reset_all);
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            m_valid[0][s] = 1'b0;
            m_valid[1][s] = 1'b0;
            if (reset_all) begin
                m_age[0][s] = '0;
                m_age[1][s] = '0;
            end
        end
    endfunction

    task automatic do_fetch(input string name, input icache_pkg::addr_t addr);
        logic              exp_refill;
        logic              done;
        logic [31:0]       r;
        icache_pkg::word_t got;
        exp_refill = model_access(addr);
        check({name, " req_ready"}, 32'd1, 32'(o_req_ready));
        i_req_valid = 1'b1;
        i_req_addr  = addr;
        @(posedge clk);
        #2;
        i_req_valid = 1'b0;
        done = 1'b0;
        while (!done) begin
            take_bits(1, r);
            i_rsp_ready = r[0];
            @(negedge clk);   // Handshake seen mid cycle.
            if (o_rsp_valid && i_rsp_ready) begin
                got  = o_rsp_data;
                done = 1'b1;
            end
            @(posedge clk);
            #2;
        end
        i_rsp_ready = 1'b0;
        check({name, " data"}, addr ^ MEM_XOR, got);
        if (!exp_refill && refill_q.size() != 0) begin
            $display("ERROR: %s fetch of %h caused a refill request at %h the model did not expect",
                     name, addr, refill_q[0]);
            stop_with_failure();
        end
        check({name, " refill count"}, 32'(exp_refill), refill_q.size());
        if (exp_refill) begin
            check({name, " refill addr"}, addr, refill_q.pop_front());
        end
    endtask

    task automatic cfg_write(input logic [`ICACHE_CFG_AW-1:0] addr, input logic [31:0] data);
        i_cfg_wr    = 1'b1;
        i_cfg_addr  = addr;
        i_cfg_wdata = data;
        @(posedge clk);
        #2;
        i_cfg_wr = 1'b0;
    endtask

    task automatic cfg_check(input string name, input logic [`ICACHE_CFG_AW-1:0] addr,
                             input logic [31:0] exp);
        i_cfg_addr = addr;
        #1;
        check(name, exp, o_cfg_rdata);
        @(posedge clk);
        #2;
    endtask

    // Memory side of the refill port.
    initial begin
        logic [31:0]       r;
        icache_pkg::addr_t a;
        i_mem_req_ready = 1'b0;
        i_mem_rsp_valid = 1'b0;
        i_mem_rsp_data  = '0;
        wait (rst === 1'b1);
        forever begin
            @(posedge clk);
            #2;
            take_bits(2, r);
            i_mem_req_ready = (r != 0);
            @(negedge clk);
            if (o_mem_req_valid && i_mem_req_ready) begin
                a = o_mem_req_addr;
                refill_q.push_back(a);
                @(posedge clk);
                #2;
                i_mem_req_ready = 1'b0;
                take_bits(2, r);
                repeat (r) begin
                    @(posedge clk);
                    #2;
                end
                i_mem_rsp_valid = 1'b1;
                i_mem_rsp_data  = a ^ MEM_XOR;
                @(posedge clk);
                #2;
                i_mem_rsp_valid = 1'b0;
            end
        end
    end

    initial begin
        repeat (N_ACCESSES * 60) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles, the cache stopped responding",
                 N_ACCESSES * 60);
        stop_with_failure();
    end

    initial begin
        logic [31:0] t;
        logic [31:0] s;
        int          n;
        rst         = 1'b0;
        i_req_valid = 1'b0;
        i_req_addr  = '0;
        i_rsp_ready = 1'b0;
        i_cfg_wr    = 1'b0;
        i_cfg_addr  = '0;
        i_cfg_wdata = '0;
        model_clear(1'b1);
        m_enable = 1'b1;
        m_hits   = '0;
        m_misses = '0;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b1;
        @(posedge clk);
        #2;

        for (n = 0; n < 4; n++) begin
            do_fetch("cold", pool_addr(2'd0, 6'(n)));
        end
        for (n = 0; n < 4; n++) begin
            do_fetch("repeat", pool_addr(2'd0, 6'(n)));
        end
        cfg_check("hit counter", `ICACHE_CFG_HITS, m_hits);

        // Three tags fight over set 5.
        do_fetch("conflict a", pool_addr(2'd0, 6'd5));
        do_fetch("conflict b", pool_addr(2'd1, 6'd5));
        do_fetch("conflict a", pool_addr(2'd0, 6'd5));
        do_fetch("conflict c", pool_addr(2'd2, 6'd5));
        do_fetch("conflict a", pool_addr(2'd0, 6'd5));
        do_fetch("conflict b", pool_addr(2'd1, 6'd5));
        cfg_check("miss counter", `ICACHE_CFG_MISSES, m_misses);

        for (n = 0; n < N_RANDOM; n++) begin
            take_bits(2, t);
            take_bits(2, s);
            do_fetch("random", pool_addr(t[1:0], s[5:0]));
        end
        cfg_check("random hits", `ICACHE_CFG_HITS, m_hits);
        cfg_check("random misses", `ICACHE_CFG_MISSES, m_misses);

        cfg_write(`ICACHE_CFG_CTRL, {30'b0, 1'b1, m_enable});
        model_clear(1'b0);   // Flush keeps the ages.
        for (n = 0; n < 4; n++) begin
            do_fetch("after flush", pool_addr(2'd0, 6'(n)));
        end

        cfg_write(`ICACHE_CFG_CTRL, 32'd0);
        m_enable = 1'b0;
        cfg_check("ctrl off", `ICACHE_CFG_CTRL, 32'd0);
        for (n = 0; n < 4; n++) begin
            do_fetch("bypass", pool_addr(2'd0, 6'(n)));
        end
        cfg_check("bypass hits", `ICACHE_CFG_HITS, m_hits);
        cfg_check("bypass misses", `ICACHE_CFG_MISSES, m_misses);
        cfg_write(`ICACHE_CFG_CTRL, 32'd1);
        m_enable = 1'b1;
        for (n = 0; n < 4; n++) begin
            do_fetch("re-enabled", pool_addr(2'd0, 6'(n)));
        end
        cfg_check("final hits", `ICACHE_CFG_HITS, m_hits);
        cfg_check("final misses", `ICACHE_CFG_MISSES, m_misses);

        if (refill_q.size() == 0 && dut_i.props_i.fail_count == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("ERROR: %0d refill requests never matched a fetch, %0d assertion failures",
                     refill_q.size(), dut_i.props_i.fail_count);
            stop_with_failure();
        end
    end

endmodule

/* sim/tb_clk_gen.sv */
// Testbench clock source.
// Free running clock with a 40 ns period.

`timescale 1ns/1ps

module tb_clk_gen (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever #20 o_clk = ~o_clk;   // Half period.
    end

endmodule

/* source/icache_age.sv */
// Replacement state for the two ways.
// Each set keeps a saturating age per way; the older or invalid way
// is offered as the victim for the current index.

`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_age (
    input  logic             clk,
    input  logic             rst,
    input  icache_pkg::idx_t i_idx,
    input  logic             i_touch,
    input  logic             i_way,
    input  logic             i_valid0,
    input  logic             i_valid1,
    output logic             o_victim
);

    icache_pkg::age_t age0_q [`ICACHE_SETS];
    icache_pkg::age_t age1_q [`ICACHE_SETS];
    icache_pkg::age_t age0;
    icache_pkg::age_t age1;

    assign age0 = age0_q[i_idx];
    assign age1 = age1_q[i_idx];

    always_comb begin
        if (!i_valid0) begin
            o_victim = 1'b0;
        end else if (!i_valid1) begin
            o_victim = 1'b1;
        end else begin
            o_victim = (age1 > age0);   // Tie stays on way 0.
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                age0_q[s] <= '0;
                age1_q[s] <= '0;
            end
        end else if (i_touch) begin
            if (i_way) begin
                age1_q[i_idx] <= '0;
                if (age0 != `ICACHE_AGE_W'(`ICACHE_AGE_MAX)) begin
                    age0_q[i_idx] <= age0 + 1'b1;
                end
            end else begin
                age0_q[i_idx] <= '0;
                if (age1 != `ICACHE_AGE_W'(`ICACHE_AGE_MAX)) begin
                    age1_q[i_idx] <= age1 + 1'b1;
                end
            end
        end
    end

endmodule

/* source/icache_cfg.sv */
// Cache configuration registers.
// Enable bit and flush command at CTRL, free running hit and miss
// counters at HITS and MISSES. Reads are combinational.

`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_cfg (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      i_cfg_wr,
    input  logic [`ICACHE_CFG_AW-1:0] i_cfg_addr,
    input  icache_pkg::word_t         i_cfg_wdata,
    output icache_pkg::word_t         o_cfg_rdata,
    input  logic                      i_hit,
    input  logic                      i_miss,
    output logic                      o_enable,
    output logic                      o_flush
);

    icache_pkg::word_t hits_q;
    icache_pkg::word_t misses_q;
    logic              ctrl_wr;

    assign ctrl_wr = i_cfg_wr & (i_cfg_addr == `ICACHE_CFG_CTRL);
    assign o_flush = ctrl_wr & i_cfg_wdata[1];   // Acts on the write edge.

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            o_enable <= 1'b1;
        end else if (ctrl_wr) begin
            o_enable <= i_cfg_wdata[0];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            hits_q   <= '0;
            misses_q <= '0;
        end else begin
            if (i_hit) begin
                hits_q <= hits_q + 1'b1;
            end
            if (i_miss) begin
                misses_q <= misses_q + 1'b1;
            end
        end
    end

    always_comb begin
        case (i_cfg_addr)
            `ICACHE_CFG_CTRL:   o_cfg_rdata = {{(`ICACHE_WORD_W-1){1'b0}}, o_enable};
            `ICACHE_CFG_HITS:   o_cfg_rdata = hits_q;
            `ICACHE_CFG_MISSES: o_cfg_rdata = misses_q;
            default:            o_cfg_rdata = '0;
        endcase
    end

endmodule

/* source/icache_ctrl.sv */
// Instruction cache controller.
// Accepts one fetch at a time, checks both ways, and on a miss or bypass
// fetches the word over the refill port. Fills go to the victim way.

`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_ctrl (
    input  logic               clk,
    input  logic               rst,
    // Fetch port.
    input  logic               i_req_valid,
    output logic               o_req_ready,
    input  icache_pkg::addr_t  i_req_addr,
    output logic               o_rsp_valid,
    input  logic               i_rsp_ready,
    output icache_pkg::word_t  o_rsp_data,
    // Refill port.
    output logic               o_mem_req_valid,
    input  logic               i_mem_req_ready,
    output icache_pkg::addr_t  o_mem_req_addr,
    input  logic               i_mem_rsp_valid,
    input  icache_pkg::word_t  i_mem_rsp_data,
    // RAM control.
    output logic               o_rd,
    output icache_pkg::idx_t   o_idx,
    output icache_pkg::tag_t   o_wr_tag,
    output logic               o_wr0,
    output logic               o_wr1,
    output icache_pkg::word_t  o_wdata,
    input  icache_pkg::tag_t   i_tag0,
    input  icache_pkg::tag_t   i_tag1,
    input  logic               i_valid0,
    input  logic               i_valid1,
    input  icache_pkg::word_t  i_data0,
    input  icache_pkg::word_t  i_data1,
    // Age unit.
    output logic               o_touch,
    output logic               o_touch_way,
    input  logic               i_victim,
    // Configuration.
    input  logic               i_enable,
    output logic               o_hit,
    output logic               o_miss
);

    icache_pkg::ctrl_state_e state_q;
    icache_pkg::ctrl_state_e state_d;
    icache_pkg::addr_t       addr_q;
    icache_pkg::word_t       rsp_data_q;
    icache_pkg::tag_t        req_tag;
    logic                    bypass_q;
    logic                    req_pend_q;
    logic                    accept;
    logic                    hit0;
    logic                    hit1;
    logic                    lookup_hit;
    logic                    fill_evt;
    logic                    alloc;

    assign accept   = i_req_valid & o_req_ready;
    assign req_tag  = addr_q[`ICACHE_ADDR_W-1:`ICACHE_IDX_W+2];

    // Compare is skipped entirely in bypass.
    assign hit0       = ~bypass_q & i_valid0 & (i_tag0 == req_tag);
    assign hit1       = ~bypass_q & i_valid1 & (i_tag1 == req_tag);
    assign lookup_hit = hit0 | hit1;

    assign fill_evt = (state_q == icache_pkg::REFILL) & i_mem_rsp_valid;
    assign alloc    = fill_evt & ~bypass_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            icache_pkg::IDLE: begin
                if (i_req_valid) begin
                    state_d = icache_pkg::LOOKUP;
                end
            end
            icache_pkg::LOOKUP: begin
                state_d = lookup_hit ? icache_pkg::RESP : icache_pkg::REFILL;
            end
            icache_pkg::REFILL: begin
                if (i_mem_rsp_valid) begin
                    state_d = icache_pkg::RESP;
                end
            end
            icache_pkg::RESP: begin
                if (i_rsp_ready) begin
                    state_d = icache_pkg::IDLE;
                end
            end
            default: state_d = icache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q    <= icache_pkg::IDLE;
            bypass_q   <= 1'b0;
            req_pend_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                bypass_q <= ~i_enable;   // Enable sampled once per access.
            end
            if (state_q == icache_pkg::LOOKUP && !lookup_hit) begin
                req_pend_q <= 1'b1;
            end else if (i_mem_req_ready) begin
                req_pend_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= i_req_addr;
        end
        if (state_q == icache_pkg::LOOKUP && lookup_hit) begin
            rsp_data_q <= hit0 ? i_data0 : i_data1;
        end else if (fill_evt) begin
            rsp_data_q <= i_mem_rsp_data;
        end
    end

    assign o_req_ready     = (state_q == icache_pkg::IDLE);
    assign o_rsp_valid     = (state_q == icache_pkg::RESP);
    assign o_rsp_data      = rsp_data_q;
    assign o_mem_req_valid = (state_q == icache_pkg::REFILL) & req_pend_q;
    assign o_mem_req_addr  = addr_q;

    // RAMs see the incoming index in IDLE, the held one afterwards.
    assign o_rd     = accept;
    assign o_idx    = o_req_ready ? i_req_addr[`ICACHE_IDX_W+1:2]
                                  : addr_q[`ICACHE_IDX_W+1:2];
    assign o_wr_tag = req_tag;
    assign o_wdata  = i_mem_rsp_data;
    assign o_wr0    = alloc & ~i_victim;
    assign o_wr1    = alloc & i_victim;

    assign o_touch     = ((state_q == icache_pkg::LOOKUP) & lookup_hit) | alloc;
    assign o_touch_way = (state_q == icache_pkg::LOOKUP) ? ~hit0 : i_victim;

    assign o_hit  = (state_q == icache_pkg::LOOKUP) & lookup_hit;
    assign o_miss = (state_q == icache_pkg::LOOKUP) & ~bypass_q & ~lookup_hit;

endmodule

/* source/icache_data_ram.sv */
// Instruction word store for one cache way.
// Registered read, single write port used on fill.

`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_data_ram (
    input  logic              clk,
    input  logic              i_rd,
    input  icache_pkg::idx_t  i_idx,
    input  logic              i_wr,
    input  icache_pkg::word_t i_wdata,
    output icache_pkg::word_t o_rdata
);

    icache_pkg::word_t mem [`ICACHE_SETS];

    always_ff @(posedge clk) begin
        if (i_wr) begin
            mem[i_idx] <= i_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rd) begin
            o_rdata <= mem[i_idx];   // Read and write never share a cycle.
        end
    end

endmodule

/* source/icache_pkg.sv */
// Shared types for the instruction cache.
// Vector widths come from the geometry header.

`include "icache_defs.svh"

package icache_pkg;

    typedef logic [`ICACHE_ADDR_W-1:0] addr_t;   // Fetch address.
    typedef logic [`ICACHE_WORD_W-1:0] word_t;   // Instruction word.
    typedef logic [`ICACHE_IDX_W-1:0]  idx_t;    // Set index.
    typedef logic [`ICACHE_TAG_W-1:0]  tag_t;
    typedef logic [`ICACHE_AGE_W-1:0]  age_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL,
        RESP
    } ctrl_state_e;

endpackage

/* source/icache_tag_ram.sv */
// Tag store for one cache way.
// Valid bits are flops cleared by reset or flush, tags sit in an array.
// Both are read on the request accept edge.

`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_tag_ram (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_rd,
    input  icache_pkg::idx_t i_idx,
    input  logic             i_wr,
    input  icache_pkg::tag_t i_wr_tag,
    input  logic             i_flush,
    output icache_pkg::tag_t o_tag,
    output logic             o_valid
);

    logic [`ICACHE_SETS-1:0] valid_q;
    icache_pkg::tag_t        tag_mem [`ICACHE_SETS];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= '0;
        end else if (i_flush) begin
            valid_q <= '0;
        end else if (i_wr) begin
            valid_q[i_idx] <= 1'b1;
        end
    end

    // A flush on the read edge must not leak the old valid bit.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            o_valid <= 1'b0;
        end else if (i_rd) begin
            o_valid <= valid_q[i_idx] & ~i_flush;
        end
    end

    always_ff @(posedge clk) begin
        if (i_wr) begin
            tag_mem[i_idx] <= i_wr_tag;
        end
        if (i_rd) begin
            o_tag <= tag_mem[i_idx];
        end
    end

endmodule

/* source/icache_top.sv */
// Two-way instruction cache top level.
// Controller, per-way tag and data RAMs, age unit and register block.

`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      i_req_valid,
    output logic                      o_req_ready,
    input  icache_pkg::addr_t         i_req_addr,
    output logic                      o_rsp_valid,
    input  logic                      i_rsp_ready,
    output icache_pkg::word_t         o_rsp_data,
    output logic                      o_mem_req_valid,
    input  logic                      i_mem_req_ready,
    output icache_pkg::addr_t         o_mem_req_addr,
    input  logic                      i_mem_rsp_valid,
    input  icache_pkg::word_t         i_mem_rsp_data,
    input  logic                      i_cfg_wr,
    input  logic [`ICACHE_CFG_AW-1:0] i_cfg_addr,
    input  icache_pkg::word_t         i_cfg_wdata,
    output icache_pkg::word_t         o_cfg_rdata
);

    logic              rd;
    icache_pkg::idx_t  idx;
    icache_pkg::tag_t  wr_tag;
    logic              wr0;
    logic              wr1;
    icache_pkg::word_t wdata;
    icache_pkg::tag_t  tag0;
    icache_pkg::tag_t  tag1;
    logic              valid0;
    logic              valid1;
    icache_pkg::word_t data0;
    icache_pkg::word_t data1;
    logic              touch;
    logic              touch_way;
    logic              victim;
    logic              enable;
    logic              flush;
    logic              hit;
    logic              miss;

    icache_ctrl u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .i_req_valid     (i_req_valid),
        .o_req_ready     (o_req_ready),
        .i_req_addr      (i_req_addr),
        .o_rsp_valid     (o_rsp_valid),
        .i_rsp_ready     (i_rsp_ready),
        .o_rsp_data      (o_rsp_data),
        .o_mem_req_valid (o_mem_req_valid),
        .i_mem_req_ready (i_mem_req_ready),
        .o_mem_req_addr  (o_mem_req_addr),
        .i_mem_rsp_valid (i_mem_rsp_valid),
        .i_mem_rsp_data  (i_mem_rsp_data),
        .o_rd            (rd),
        .o_idx           (idx),
        .o_wr_tag        (wr_tag),
        .o_wr0           (wr0),
        .o_wr1           (wr1),
        .o_wdata         (wdata),
        .i_tag0          (tag0),
        .i_tag1          (tag1),
        .i_valid0        (valid0),
        .i_valid1        (valid1),
        .i_data0         (data0),
        .i_data1         (data1),
        .o_touch         (touch),
        .o_touch_way     (touch_way),
        .i_victim        (victim),
        .i_enable        (enable),
        .o_hit           (hit),
        .o_miss          (miss)
    );

    icache_cfg u_cfg (
        .clk         (clk),
        .rst         (rst),
        .i_cfg_wr    (i_cfg_wr),
        .i_cfg_addr  (i_cfg_addr),
        .i_cfg_wdata (i_cfg_wdata),
        .o_cfg_rdata (o_cfg_rdata),
        .i_hit       (hit),
        .i_miss      (miss),
        .o_enable    (enable),
        .o_flush     (flush)
    );

    icache_age u_age (
        .clk      (clk),
        .rst      (rst),
        .i_idx    (idx),
        .i_touch  (touch),
        .i_way    (touch_way),
        .i_valid0 (valid0),
        .i_valid1 (valid1),
        .o_victim (victim)
    );

    icache_tag_ram u_tag0 (
        .clk      (clk),
        .rst      (rst),
        .i_rd     (rd),
        .i_idx    (idx),
        .i_wr     (wr0),
        .i_wr_tag (wr_tag),
        .i_flush  (flush),
        .o_tag    (tag0),
        .o_valid  (valid0)
    );

    icache_tag_ram u_tag1 (
        .clk      (clk),
        .rst      (rst),
        .i_rd     (rd),
        .i_idx    (idx),
        .i_wr     (wr1),
        .i_wr_tag (wr_tag),
        .i_flush  (flush),
        .o_tag    (tag1),
        .o_valid  (valid1)
    );

    icache_data_ram u_data0 (
        .clk     (clk),
        .i_rd    (rd),
        .i_idx   (idx),
        .i_wr    (wr0),
        .i_wdata (wdata),
        .o_rdata (data0)
    );

    icache_data_ram u_data1 (
        .clk     (clk),
        .i_rd    (rd),
        .i_idx   (idx),
        .i_wr    (wr1),
        .i_wdata (wdata),
        .o_rdata (data1)
    );

endmodule

/* tb.f */
+incdir+include
source/icache_pkg.sv
source/icache_tag_ram.sv
source/icache_data_ram.sv
source/icache_age.sv
source/icache_ctrl.sv
source/icache_cfg.sv
source/icache_top.sv
sim/tb_clk_gen.sv
sim/icache_props.sv
sim/icache_tb.sv
